// File: include/ym_macros.svh
// Timer block register map and timing constants
`ifndef YM_MACROS_SVH
`define YM_MACROS_SVH

// Register numbers on the data port
`define YM_REG_TIMER_A_HI 8'h24 // Timer A bits 9..2
`define YM_REG_TIMER_A_LO 8'h25 // Timer A bits 1..0
`define YM_REG_TIMER_B    8'h26
`define YM_REG_TIMER_CTL  8'h27 // Load, irq enable and flag reset bits

// cen cycles per timer A tick
`define YM_PRESCALE 8

// Timer A ticks per timer B tick
`define YM_TIMER_B_DIV 16

// cen cycles with busy high after a data write
`define YM_BUSY_CYCLES 32

`endif

// File: hw/ym_reg_pkg.sv
// Bus and register map types
package ym_reg_pkg;

    // Bus address, bit 0 picks register number or data port
    typedef logic [1:0] bus_addr_t;

    // Write data and status byte
    typedef logic [7:0] bus_data_t;

    // Register number latched by an address write
    typedef logic [7:0] reg_num_t;

endpackage

// File: hw/ym_timer_pkg.sv
// Timer value and busy FSM types
package ym_timer_pkg;

    typedef logic [9:0] timer_a_t; // Timer A reload value
    typedef logic [7:0] timer_b_t; // Timer B reload value

    // Busy generation after data writes
    typedef enum logic [0:0] {
        BUSY_IDLE,
        BUSY_COUNT
    } busy_state_t;

endpackage

// File: hw/ym_cpu_port.sv
// CPU bus write port
`timescale 1ns/1ps
`include "ym_macros.svh"

module ym_cpu_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen,
    input  ym_reg_pkg::bus_data_t  din,
    input  ym_reg_pkg::bus_addr_t  addr,
    input  logic                   cs_n,
    input  logic                   wr_n,
    output ym_timer_pkg::timer_a_t value_a,
    output ym_timer_pkg::timer_b_t value_b,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   irq_en_a,
    output logic                   irq_en_b,
    output logic                   clr_flag_a,
    output logic                   clr_flag_b,
    output logic                   busy
);

    localparam int BUSY_W = $clog2(`YM_BUSY_CYCLES);

    ym_reg_pkg::reg_num_t     reg_num;
    ym_timer_pkg::busy_state_t busy_state;
    logic [BUSY_W-1:0]        busy_cnt;
    logic                     write;
    logic                     addr_wr;
    logic                     data_wr;
    logic                     ctl_wr;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];
    assign ctl_wr  = data_wr && (reg_num == `YM_REG_TIMER_CTL);

    // Register number latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_num <= '0;
        end else if (addr_wr) begin
            reg_num <= din;
        end
    end

    // Timer values and control levels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_a  <= '0;
            value_b  <= '0;
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
        end else if (data_wr) begin
            case (reg_num)
                `YM_REG_TIMER_A_HI: value_a[9:2] <= din;
                `YM_REG_TIMER_A_LO: value_a[1:0] <= din[1:0];
                `YM_REG_TIMER_B:    value_b      <= din;
                `YM_REG_TIMER_CTL: begin
                    load_a   <= din[0];
                    load_b   <= din[1];
                    irq_en_a <= din[2];
                    irq_en_b <= din[3];
                end
                default: ; // Unknown registers are ignored
            endcase
        end
    end

    // Flag reset strobes, single cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
        end else begin
            clr_flag_a <= ctl_wr && din[4];
            clr_flag_b <= ctl_wr && din[5];
        end
    end

    // Busy FSM, restarts on every data write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_state <= ym_timer_pkg::BUSY_IDLE;
            busy_cnt   <= '0;
        end else if (data_wr) begin
            busy_state <= ym_timer_pkg::BUSY_COUNT;
            busy_cnt   <= '0;
        end else if (busy_state == ym_timer_pkg::BUSY_COUNT && cen) begin
            if (busy_cnt == BUSY_W'(`YM_BUSY_CYCLES - 1)) begin
                busy_state <= ym_timer_pkg::BUSY_IDLE; // Last counted cycle
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    assign busy = (busy_state == ym_timer_pkg::BUSY_COUNT);

endmodule

// File: hw/ym_timer_base.sv
// Timer tick prescaler
`timescale 1ns/1ps
`include "ym_macros.svh"

module ym_timer_base (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    output logic tick_a,
    output logic tick_b
);

    localparam int PRE_W = $clog2(`YM_PRESCALE);
    localparam int SUB_W = $clog2(`YM_TIMER_B_DIV);

    logic [PRE_W-1:0] pre_cnt;
    logic [SUB_W-1:0] sub_cnt; // Counts tick_a for timer B

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            sub_cnt <= '0;
            tick_a  <= 1'b0;
            tick_b  <= 1'b0;
        end else begin
            tick_a <= 1'b0;
            tick_b <= 1'b0;
            if (cen) begin
                if (pre_cnt == PRE_W'(`YM_PRESCALE - 1)) begin
                    pre_cnt <= '0;
                    tick_a  <= 1'b1;
                    if (sub_cnt == SUB_W'(`YM_TIMER_B_DIV - 1)) begin
                        sub_cnt <= '0;
                        tick_b  <= 1'b1; // Sixteen times slower than A
                    end else begin
                        sub_cnt <= sub_cnt + 1'b1;
                    end
                end else begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/ym_timer_counter.sv
// Reloading timer counter
`timescale 1ns/1ps

module ym_timer_counter #(
    parameter int width = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic             load,
    input  logic [width-1:0] value,
    output logic             overflow
);

    logic [width-1:0] count;
    logic             full;

    assign full = &count;

    // Counts up from value, overflow at full scale
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (!load) begin
                count <= value; // Stopped, tracks the register
            end else if (tick) begin
                if (full) begin
                    count    <= value;
                    overflow <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/ym_status_irq.sv
// Timer flags, status byte and interrupt
`timescale 1ns/1ps

module ym_status_irq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  overflow_a,
    input  logic                  overflow_b,
    input  logic                  irq_en_a,
    input  logic                  irq_en_b,
    input  logic                  clr_flag_a,
    input  logic                  clr_flag_b,
    input  logic                  busy,
    output ym_reg_pkg::bus_data_t dout,
    output logic                  irq_n
);

    logic flag_a;
    logic flag_b;

    // Clear has priority over a new overflow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
        end else if (clr_flag_a) begin
            flag_a <= 1'b0;
        end else if (overflow_a && irq_en_a) begin
            flag_a <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_b <= 1'b0;
        end else if (clr_flag_b) begin
            flag_b <= 1'b0;
        end else if (overflow_b && irq_en_b) begin
            flag_b <= 1'b1;
        end
    end

    // Status byte and irq_n move on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout  <= '0;
            irq_n <= 1'b1;
        end else begin
            dout  <= {busy, 5'd0, flag_b, flag_a};
            irq_n <= !(flag_a || flag_b); // Active low
        end
    end

endmodule

// File: hw/ym_timer_top.sv
// FM chip timer block top
`timescale 1ns/1ps

module ym_timer_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  ym_reg_pkg::bus_data_t din,
    input  ym_reg_pkg::bus_addr_t addr,
    input  logic                  cs_n,
    input  logic                  wr_n,
    output ym_reg_pkg::bus_data_t dout,
    output logic                  irq_n
);

    ym_timer_pkg::timer_a_t value_a;
    ym_timer_pkg::timer_b_t value_b;
    logic                   load_a;
    logic                   load_b;
    logic                   irq_en_a;
    logic                   irq_en_b;
    logic                   clr_flag_a;
    logic                   clr_flag_b;
    logic                   busy;
    logic                   tick_a;
    logic                   tick_b;
    logic                   overflow_a;
    logic                   overflow_b;

    ym_cpu_port u_cpu_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen),
        .din        (din),
        .addr       (addr),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .value_a    (value_a),
        .value_b    (value_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .irq_en_a   (irq_en_a),
        .irq_en_b   (irq_en_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .busy       (busy)
    );

    ym_timer_base u_timer_base (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .tick_a (tick_a),
        .tick_b (tick_b)
    );

    ym_timer_counter #(.width(10)) u_timer_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick_a),
        .load     (load_a),
        .value    (value_a),
        .overflow (overflow_a)
    );

    ym_timer_counter #(.width(8)) u_timer_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick_b),
        .load     (load_b),
        .value    (value_b),
        .overflow (overflow_b)
    );

    // Each enable gates its own timer flag
    ym_status_irq u_status_irq (
        .clk        (clk),
        .rst_n      (rst_n),
        .overflow_a (overflow_a),
        .overflow_b (overflow_b),
        .irq_en_a   (irq_en_a),
        .irq_en_b   (irq_en_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .busy       (busy),
        .dout       (dout),
        .irq_n      (irq_n)
    );

endmodule

// File: sim/ym_timer_assertions.sv
// Timer block bound assertions
`timescale 1ns/1ps

module ym_timer_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  cs_n,
    input logic                  wr_n,
    input logic                  busy,
    input ym_reg_pkg::bus_data_t dout,
    input logic                  irq_n
);

    int fail_count = 0; // Assertion failures so far

    // Status byte and irq_n are registered from the same flags
    ap_irq_follows_flags: assert property (
        @(posedge clk) disable iff (!rst_n) (dout[1:0] == 2'b00) |-> irq_n
    ) else begin
        $error("irq_n low while both flag bits are clear");
        fail_count++;
    end

    ap_busy_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !busy
    ) else begin
        $error("busy high in the cycle after reset");
        fail_count++;
    end

    ap_no_write_in_reset: assert property (
        @(posedge clk) !rst_n |-> (cs_n || wr_n)
    ) else begin
        $error("bus write issued while reset is active");
        fail_count++;
    end

endmodule

bind ym_timer_top ym_timer_assertions u_assertions (
    .clk   (clk),
    .rst_n (rst_n),
    .cs_n  (cs_n),
    .wr_n  (wr_n),
    .busy  (busy),
    .dout  (dout),
    .irq_n (irq_n)
);

// File: sim/tb_ym_timer_top.sv
// Timer block testbench
`timescale 1ns/1ps
`include "ym_macros.svh"

module tb_ym_timer_top;

    logic                   clk;
    logic                   rst_n;
    logic                   cen;
    ym_reg_pkg::bus_data_t  din;
    ym_reg_pkg::bus_addr_t  addr;
    logic                   cs_n;
    logic                   wr_n;
    ym_reg_pkg::bus_data_t  dout;
    logic                   irq_n;

    int                     id;
    int                     op;
    ym_timer_pkg::timer_a_t a_val;
    ym_timer_pkg::timer_b_t b_val;
    ym_reg_pkg::bus_data_t  ctl;
    int                     wait_cycles;
    logic [1:0]             exp_flags;
    logic                   exp_irq;
    int                     case_errors; // Checks failed in the current test
    int                     passed;
    int                     failed;

    ym_timer_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .din   (din),
        .addr  (addr),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .dout  (dout),
        .irq_n (irq_n)
    );

    always #5 clk = ~clk;

    // One bus cycle, driven between falling edges
    task automatic bus_write(input ym_reg_pkg::bus_addr_t a, input ym_reg_pkg::bus_data_t d);
        @(negedge clk);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input ym_reg_pkg::reg_num_t num, input ym_reg_pkg::bus_data_t d);
        bus_write(2'd0, num); // Register number port
        bus_write(2'd1, d);   // Data port
    endtask

    task automatic program_timers(input ym_timer_pkg::timer_a_t a,
                                  input ym_timer_pkg::timer_b_t b,
                                  input ym_reg_pkg::bus_data_t c);
        write_reg(`YM_REG_TIMER_A_HI, a[9:2]);
        write_reg(`YM_REG_TIMER_A_LO, {6'd0, a[1:0]});
        write_reg(`YM_REG_TIMER_B, b);
        write_reg(`YM_REG_TIMER_CTL, c);
    endtask

    task automatic report_mismatch(input string sig, input int exp, input int got);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, exp, got);
        case_errors++;
    endtask

    // Expected period from the register values, plus two prescaler periods
    function automatic int rule_bound(input int o, input int a, input int b, input int c);
        int period;
        int result;
        period = 0;
        if (c[0] || c[2]) begin
            period = (1024 - a) * `YM_PRESCALE;
        end
        if ((c[1] || c[3]) && (256 - b) * `YM_PRESCALE * `YM_TIMER_B_DIV > period) begin
            period = (256 - b) * `YM_PRESCALE * `YM_TIMER_B_DIV;
        end
        if (o == 0) result = 0;
        else if (o == 1) result = `YM_BUSY_CYCLES + 4;
        else result = period + 2 * `YM_PRESCALE;
        return result;
    endfunction

    task automatic wait_flags(input int bound, input logic [1:0] exp, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < bound) begin
            @(negedge clk);
            n++;
            if (dout[1:0] === exp) ok = 1'b1;
        end
    endtask

    task automatic wait_busy(input logic level, input int bound, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < bound) begin
            @(negedge clk);
            n++;
            if (dout[7] === level) ok = 1'b1;
        end
    endtask

    task automatic hold_flags(input int bound, input logic [1:0] exp, input logic exp_i);
        int n;
        n = 0;
        while (case_errors == 0 && n < bound) begin
            @(negedge clk);
            n++;
            if (dout[1:0] !== exp) report_mismatch("dout[1:0]", exp, dout[1:0]);
            if (irq_n !== exp_i) report_mismatch("irq_n", exp_i, irq_n);
        end
    endtask

    task automatic run_case();
        bit ok;
        int bound;
        case_errors = 0;
        bound = rule_bound(op, a_val, b_val, ctl);
        if (wait_cycles < bound) begin
            $display("Test %0d waits %0d cycles, less than the %0d the timer rules need",
                     id, wait_cycles, bound);
            case_errors++;
        end
        case (op)
            0: begin
                @(negedge clk);
                if (dout !== {6'd0, exp_flags}) report_mismatch("dout", exp_flags, dout);
                if (irq_n !== exp_irq) report_mismatch("irq_n", exp_irq, irq_n);
            end
            1: begin
                write_reg(`YM_REG_TIMER_B, b_val);
                wait_busy(1'b1, 4, ok);
                if (!ok) begin
                    $display("Test %0d saw no busy bit after a data write", id);
                    case_errors++;
                end
                wait_busy(1'b0, wait_cycles, ok);
                if (!ok) begin
                    $display("Test %0d timed out waiting for busy to clear", id);
                    case_errors++;
                end
            end
            2: begin
                program_timers(a_val, b_val, ctl);
                wait_flags(wait_cycles, exp_flags, ok);
                if (!ok) begin
                    $display("Test %0d timed out after %0d cycles waiting for flags %b",
                             id, wait_cycles, exp_flags);
                    case_errors++;
                end else if (irq_n !== exp_irq) begin
                    report_mismatch("irq_n", exp_irq, irq_n);
                end
            end
            3: begin
                program_timers(a_val, b_val, ctl);
                wait_flags(2 * `YM_PRESCALE, exp_flags, ok); // Pending flag clears first
                if (!ok) begin
                    $display("Test %0d flags never settled to %b", id, exp_flags);
                    case_errors++;
                end else begin
                    hold_flags(wait_cycles, exp_flags, exp_irq);
                end
            end
            default: begin
                $display("Test %0d has unknown operation %0d", id, op);
                case_errors++;
            end
        endcase
        if (case_errors == 0) begin
            passed++;
            $display("Test %0d passed", id);
        end else begin
            failed++;
            $display("Test %0d failed with %0d errors", id, case_errors);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    skip;
        bit    done;
        logic [8*256-1:0] line;
        clk    = 1'b0;
        rst_n  = 1'b0;
        cen    = 1'b1;
        din    = '0;
        addr   = '0;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        passed = 0;
        failed = 0;
        done   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("sim/ym_timer_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file sim/ym_timer_cases.txt");
            failed++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%d %d %h %h %h %d %h %d\n", id, op, a_val, b_val, ctl,
                           wait_cycles, exp_flags, exp_irq);
            if (code == 8) begin
                run_case();
            end else if (code == -1) begin
                done = 1'b1;
            end else begin
                skip = $fgets(line, fd); // Comment line
                if (skip == 0) done = 1'b1;
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 passed + failed, passed, failed, dut0.u_assertions.fail_count);
        if (failed == 0 && passed > 0 && dut0.u_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: ym_timer_top.f
+incdir+include
hw/ym_reg_pkg.sv
hw/ym_timer_pkg.sv
hw/ym_cpu_port.sv
hw/ym_timer_base.sv
hw/ym_timer_counter.sv
hw/ym_status_irq.sv
hw/ym_timer_top.sv
sim/ym_timer_assertions.sv
sim/tb_ym_timer_top.sv

// File: Bender.yml
package:
  name: ym_timer

export_include_dirs:
  - include

sources:
  - files:
      - hw/ym_reg_pkg.sv
      - hw/ym_timer_pkg.sv
      - hw/ym_cpu_port.sv
      - hw/ym_timer_base.sv
      - hw/ym_timer_counter.sv
      - hw/ym_status_irq.sv
      - hw/ym_timer_top.sv
  - target: simulation
    files:
      - sim/ym_timer_assertions.sv
      - sim/tb_ym_timer_top.sv

// File: sim/ym_timer_cases.txt
# id op timer_a(hex) timer_b(hex) ctl(hex) wait_cycles flags(hex) irq_n
# op 0 reset check, 1 busy check, 2 wait for flags, 3 hold flags through wait
1 0 000 00 00 0   0 1
2 1 000 80 00 36  0 1
3 2 3e8 00 35 208 1 0
4 2 3e8 00 10 16  0 1
5 3 000 fe 32 272 0 1
6 2 000 fe 3a 272 2 0
7 3 3fc 00 34 96  0 1
